// ==== rtl/mem_settings.svh ====
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// ***************************************************************************
// sizing of the interleaved memory subsystem.
// ***************************************************************************

// requester word address width.
// the low bit selects the bank so each bank sees one bit less.
`define MEM_ADDR_W 10

// data word width in bits.
// always a multiple of 8.
`define MEM_DATA_W 32

// outstanding requests tracked for in-order return.
`define MEM_ORDER_DEPTH 4

`endif

// ==== rtl/mem_pkg.sv ====
`include "mem_settings.svh"

package mem_pkg;

   // ************************************************************************
   // data word views.
   // ************************************************************************

   parameter int MEM_LANES = `MEM_DATA_W / 8;  // byte lanes per word.

   // one data word.
   // the controller moves it whole and the RAM writes it lane by lane.
   typedef union packed {
      logic [`MEM_DATA_W-1:0]    word;
      logic [MEM_LANES-1:0][7:0] lane;
   } mem_word_u;

endpackage

// ==== rtl/byte_ram_sp.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module byte_ram_sp
   import mem_pkg::*;
#(
   parameter int ADDR_W = `MEM_ADDR_W - 1
) (
   input  logic                 clk_i,
   input  logic                 en_i,
   input  logic [MEM_LANES-1:0] we_i,
   input  logic [ADDR_W-1:0]    addr_i,
   input  mem_word_u            d_i,
   output mem_word_u            d_o
);

   localparam int DEPTH = 2 ** ADDR_W;

   // ************************************************************************
   // storage and read port.
   // ************************************************************************

   mem_word_u ram_q [DEPTH];
   mem_word_u rd_q;  // output register.

   // read-first.
   // the old word is captured in the same edge that writes the lanes.
   always_ff @(posedge clk_i) begin
      if (en_i) begin
         for (int i = 0; i < MEM_LANES; i++) begin
            if (we_i[i]) begin
               ram_q[addr_i].lane[i] <= d_i.lane[i];  // masked lane write.
            end
         end
         rd_q <= ram_q[addr_i];
      end
   end

   // held while en_i is low.
   assign d_o = rd_q;

endmodule

// ==== rtl/mem_bank.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module mem_bank
   import mem_pkg::*;
#(
   parameter int ADDR_W = `MEM_ADDR_W - 1
) (
   input  logic                 clk_i,
   input  logic                 arst_n_i,

   // request channel.
   input  logic                 req_valid_i,
   input  logic                 req_we_i,
   input  logic [ADDR_W-1:0]    req_addr_i,
   input  logic [MEM_LANES-1:0] req_be_i,
   input  mem_word_u            req_wdata_i,
   output logic                 req_ready_o,

   // response channel.
   output logic                 rsp_valid_o,
   output mem_word_u            rsp_rdata_o,
   input  logic                 rsp_ready_i
);

   logic                 req_fire;
   logic [MEM_LANES-1:0] ram_we;
   logic                 rsp_valid_q;

   // ************************************************************************
   // request side.
   // ************************************************************************

   // free slot, or the held response leaves this cycle.
   assign req_ready_o = ~rsp_valid_q | rsp_ready_i;
   assign req_fire    = req_valid_i & req_ready_o;

   assign ram_we = {MEM_LANES{req_we_i}} & req_be_i;  // reads write nothing.

   byte_ram_sp #(
      .ADDR_W(ADDR_W)
   ) u_ram (
      .clk_i (clk_i),
      .en_i  (req_fire),
      .we_i  (ram_we),
      .addr_i(req_addr_i),
      .d_i   (req_wdata_i),
      .d_o   (rsp_rdata_o)
   );

   // ************************************************************************
   // response stage.
   // ************************************************************************

   // the RAM output register is the payload.
   // only its valid flag lives here.
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         rsp_valid_q <= 1'b0;
      end else if (req_fire) begin
         rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
         rsp_valid_q <= 1'b0;  // drained.
      end
   end

   assign rsp_valid_o = rsp_valid_q;

   // a stalled response keeps its data until taken.
   a_rsp_stable : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      rsp_valid_o && !rsp_ready_i |=> $stable(rsp_rdata_o)
   );

endmodule

// ==== rtl/interleave_ctrl.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module interleave_ctrl
   import mem_pkg::*;
#(
   parameter int ADDR_W = `MEM_ADDR_W,
   parameter int DEPTH  = `MEM_ORDER_DEPTH
) (
   input  logic                 clk_i,
   input  logic                 arst_n_i,

   // requester.
   input  logic                 req_valid_i,
   input  logic                 req_we_i,
   input  logic [ADDR_W-1:0]    req_addr_i,
   input  logic [MEM_LANES-1:0] req_be_i,
   input  mem_word_u            req_wdata_i,
   output logic                 req_ready_o,

   // bank 0.
   output logic                 b0_req_valid_o,
   output logic                 b0_req_we_o,
   output logic [ADDR_W-2:0]    b0_req_addr_o,
   output logic [MEM_LANES-1:0] b0_req_be_o,
   output mem_word_u            b0_req_wdata_o,
   input  logic                 b0_req_ready_i,
   input  logic                 b0_rsp_valid_i,
   input  mem_word_u            b0_rsp_rdata_i,
   output logic                 b0_rsp_ready_o,

   // bank 1.
   output logic                 b1_req_valid_o,
   output logic                 b1_req_we_o,
   output logic [ADDR_W-2:0]    b1_req_addr_o,
   output logic [MEM_LANES-1:0] b1_req_be_o,
   output mem_word_u            b1_req_wdata_o,
   input  logic                 b1_req_ready_i,
   input  logic                 b1_rsp_valid_i,
   input  mem_word_u            b1_rsp_rdata_i,
   output logic                 b1_rsp_ready_o,

   // responses.
   output logic                 rsp_valid_o,
   output mem_word_u            rsp_rdata_o,
   input  logic                 rsp_ready_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic             bank_sel;
   logic             q_full;
   logic             q_empty;
   logic             head_bank;
   logic             push;
   logic             pop;
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] cnt_q;
   logic             order_q [DEPTH];  // bank index per outstanding request.

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

   // ************************************************************************
   // request steering.
   // ************************************************************************

   assign bank_sel    = req_addr_i[0];
   assign q_full      = (cnt_q == CNT_W'(DEPTH));
   assign q_empty     = (cnt_q == '0);
   assign req_ready_o = (bank_sel ? b1_req_ready_i : b0_req_ready_i) & ~q_full;
   assign push        = req_valid_i & req_ready_o;

   assign b0_req_valid_o = req_valid_i & ~q_full & ~bank_sel;
   assign b1_req_valid_o = req_valid_i & ~q_full & bank_sel;

   assign b0_req_we_o         = req_we_i;
   assign b1_req_we_o         = req_we_i;
   assign b0_req_addr_o       = req_addr_i[ADDR_W-1:1];  // bank bit dropped.
   assign b1_req_addr_o       = req_addr_i[ADDR_W-1:1];
   assign b0_req_be_o         = req_be_i;
   assign b1_req_be_o         = req_be_i;
   assign b0_req_wdata_o.word = req_wdata_i.word;
   assign b1_req_wdata_o.word = req_wdata_i.word;

   // ************************************************************************
   // order queue and response merge.
   // ************************************************************************

   always_ff @(posedge clk_i) begin
      if (push) begin
         order_q[wr_ptr_q] <= bank_sel;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         cnt_q    <= '0;
      end else begin
         if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop)  rd_ptr_q <= ptr_inc(rd_ptr_q);
         case ({push, pop})
            2'b10:   cnt_q <= cnt_q + 1'b1;
            2'b01:   cnt_q <= cnt_q - 1'b1;
            default: cnt_q <= cnt_q;  // none, or both.
         endcase
      end
   end

   assign head_bank = order_q[rd_ptr_q];

   // only the head bank may present a response.
   assign rsp_valid_o      = ~q_empty & (head_bank ? b1_rsp_valid_i : b0_rsp_valid_i);
   assign rsp_rdata_o.word = head_bank ? b1_rsp_rdata_i.word : b0_rsp_rdata_i.word;
   assign pop              = rsp_valid_o & rsp_ready_i;

   assign b0_rsp_ready_o = rsp_ready_i & ~q_empty & ~head_bank;
   assign b1_rsp_ready_o = rsp_ready_i & ~q_empty & head_bank;

   a_no_push_full : assert property (
      @(posedge clk_i) disable iff (!arst_n_i) q_full |-> !push
   );

   a_no_pop_empty : assert property (
      @(posedge clk_i) disable iff (!arst_n_i) q_empty |-> !pop
   );

   // a bank response with no request on record.
   a_no_orphan_rsp : assert property (
      @(posedge clk_i) disable iff (!arst_n_i)
      q_empty |-> !b0_rsp_valid_i && !b1_rsp_valid_i
   );

endmodule

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module mem_subsys_top
   import mem_pkg::*;
(
   input  logic                     clk_i,
   input  logic                     arst_n_i,

   input  logic                     req_valid_i,
   input  logic                     req_we_i,
   input  logic [`MEM_ADDR_W-1:0]   req_addr_i,
   input  logic [MEM_LANES-1:0]     req_be_i,
   input  mem_word_u                req_wdata_i,
   output logic                     req_ready_o,

   output logic                     rsp_valid_o,
   output mem_word_u                rsp_rdata_o,
   input  logic                     rsp_ready_i
);

   localparam int BANK_ADDR_W = `MEM_ADDR_W - 1;

   // ************************************************************************
   // bank channels.
   // ************************************************************************

   logic                   b0_req_valid, b1_req_valid;
   logic                   b0_req_we, b1_req_we;
   logic [BANK_ADDR_W-1:0] b0_req_addr, b1_req_addr;
   logic [MEM_LANES-1:0]   b0_req_be, b1_req_be;
   mem_word_u              b0_req_wdata, b1_req_wdata;
   logic                   b0_req_ready, b1_req_ready;
   logic                   b0_rsp_valid, b1_rsp_valid;
   mem_word_u              b0_rsp_rdata, b1_rsp_rdata;
   logic                   b0_rsp_ready, b1_rsp_ready;

   interleave_ctrl #(
      .ADDR_W(`MEM_ADDR_W),
      .DEPTH (`MEM_ORDER_DEPTH)
   ) u_ctrl (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .req_valid_i   (req_valid_i),
      .req_we_i      (req_we_i),
      .req_addr_i    (req_addr_i),
      .req_be_i      (req_be_i),
      .req_wdata_i   (req_wdata_i),
      .req_ready_o   (req_ready_o),
      .b0_req_valid_o(b0_req_valid),
      .b0_req_we_o   (b0_req_we),
      .b0_req_addr_o (b0_req_addr),
      .b0_req_be_o   (b0_req_be),
      .b0_req_wdata_o(b0_req_wdata),
      .b0_req_ready_i(b0_req_ready),
      .b0_rsp_valid_i(b0_rsp_valid),
      .b0_rsp_rdata_i(b0_rsp_rdata),
      .b0_rsp_ready_o(b0_rsp_ready),
      .b1_req_valid_o(b1_req_valid),
      .b1_req_we_o   (b1_req_we),
      .b1_req_addr_o (b1_req_addr),
      .b1_req_be_o   (b1_req_be),
      .b1_req_wdata_o(b1_req_wdata),
      .b1_req_ready_i(b1_req_ready),
      .b1_rsp_valid_i(b1_rsp_valid),
      .b1_rsp_rdata_i(b1_rsp_rdata),
      .b1_rsp_ready_o(b1_rsp_ready),
      .rsp_valid_o   (rsp_valid_o),
      .rsp_rdata_o   (rsp_rdata_o),
      .rsp_ready_i   (rsp_ready_i)
   );

   // even word addresses.
   mem_bank #(
      .ADDR_W(BANK_ADDR_W)
   ) bank0 (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_valid_i(b0_req_valid),
      .req_we_i   (b0_req_we),
      .req_addr_i (b0_req_addr),
      .req_be_i   (b0_req_be),
      .req_wdata_i(b0_req_wdata),
      .req_ready_o(b0_req_ready),
      .rsp_valid_o(b0_rsp_valid),
      .rsp_rdata_o(b0_rsp_rdata),
      .rsp_ready_i(b0_rsp_ready)
   );

   // odd word addresses.
   mem_bank #(
      .ADDR_W(BANK_ADDR_W)
   ) bank1 (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_valid_i(b1_req_valid),
      .req_we_i   (b1_req_we),
      .req_addr_i (b1_req_addr),
      .req_be_i   (b1_req_be),
      .req_wdata_i(b1_req_wdata),
      .req_ready_o(b1_req_ready),
      .rsp_valid_o(b1_rsp_valid),
      .rsp_rdata_o(b1_rsp_rdata),
      .rsp_ready_i(b1_rsp_ready)
   );

endmodule

// ==== bench/tb_mem_subsys.sv ====
`timescale 1ns/1ps

`include "mem_settings.svh"

module tb_mem_subsys
   import mem_pkg::*;
();

   localparam int TIMEOUT = 200;  // cycles per wait.
   localparam int WORDS   = 2 ** `MEM_ADDR_W;

   logic                   clk_i = 1'b0;
   logic                   arst_n_i;
   logic                   req_valid_i;
   logic                   req_we_i;
   logic [`MEM_ADDR_W-1:0] req_addr_i;
   logic [MEM_LANES-1:0]   req_be_i;
   mem_word_u              req_wdata_i;
   logic                   req_ready_o;
   logic                   rsp_valid_o;
   mem_word_u              rsp_rdata_o;
   logic                   rsp_ready_i;

   logic [`MEM_DATA_W-1:0] model_mem [WORDS];  // unknown until written.
   logic [`MEM_DATA_W-1:0] exp_q [$];          // expected responses in order.
   logic [`MEM_DATA_W-1:0] exp_word;
   logic [`MEM_ADDR_W-1:0] rnd_addr;
   string                  test_name = "reset";
   bit                     rand_ready = 1'b0;
   int                     mismatch_cnt = 0;
   int                     unexpected_cnt = 0;
   int                     timeout_cnt = 0;

   mem_subsys_top UUT (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .req_valid_i(req_valid_i),
      .req_we_i   (req_we_i),
      .req_addr_i (req_addr_i),
      .req_be_i   (req_be_i),
      .req_wdata_i(req_wdata_i),
      .req_ready_o(req_ready_o),
      .rsp_valid_o(rsp_valid_o),
      .rsp_rdata_o(rsp_rdata_o),
      .rsp_ready_i(rsp_ready_i)
   );

   always #2 clk_i = ~clk_i;

   always @(negedge clk_i) begin
      rsp_ready_i = rand_ready ? ($urandom % 4 != 0) : 1'b1;  // back-pressure.
   end

   // ************************************************************************
   // reference model and response checking.
   // ************************************************************************

   always @(posedge clk_i) begin
      if (arst_n_i) begin
         // responses belong to earlier requests, so pop before push.
         if (rsp_valid_o && rsp_ready_i) begin
            if (exp_q.size() == 0) begin
               unexpected_cnt++;
               $display("ERROR %s: response arrived with no request outstanding", test_name);
            end else begin
               exp_word = exp_q.pop_front();
               a_rsp_data: assert (rsp_rdata_o.word === exp_word) else begin
                  mismatch_cnt++;
                  $display("MISMATCH %s: expected %h actual %h",
                           test_name, exp_word, rsp_rdata_o.word);
               end
            end
         end
         if (req_valid_i && req_ready_o) begin
            exp_q.push_back(model_mem[req_addr_i]);  // read-first.
            if (req_we_i) begin
               for (int i = 0; i < MEM_LANES; i++) begin
                  if (req_be_i[i]) model_mem[req_addr_i][8*i +: 8] = req_wdata_i.word[8*i +: 8];
               end
            end
         end
      end
   end

   // ************************************************************************
   // stimulus tasks.
   // ************************************************************************

   // returns at the edge that accepts the request.
   task automatic send_req(input logic we, input logic [`MEM_ADDR_W-1:0] addr,
                           input logic [MEM_LANES-1:0] be,
                           input logic [`MEM_DATA_W-1:0] data);
      int waited;
      waited = 0;
      @(negedge clk_i);
      req_valid_i      = 1'b1;
      req_we_i         = we;
      req_addr_i       = addr;
      req_be_i         = be;
      req_wdata_i.word = data;
      @(posedge clk_i);
      while (!req_ready_o && waited < TIMEOUT) begin
         waited++;
         @(posedge clk_i);
      end
      if (!req_ready_o) begin
         timeout_cnt++;
         $display("ERROR %s: request to address %h was never accepted", test_name, addr);
         @(negedge clk_i);
         req_valid_i = 1'b0;
      end
   endtask

   task automatic idle(input int cycles);
      @(negedge clk_i);
      req_valid_i = 1'b0;
      repeat (cycles - 1) @(negedge clk_i);
   endtask

   // waits until every expected response was consumed.
   task automatic drain();
      int waited;
      waited = 0;
      while (exp_q.size() != 0 && waited < TIMEOUT) begin
         waited++;
         @(negedge clk_i);
      end
      if (exp_q.size() != 0) begin
         timeout_cnt++;
         $display("ERROR %s: %0d responses never arrived", test_name, exp_q.size());
      end
   endtask

   // ************************************************************************
   // test sequence.
   // ************************************************************************

   initial begin
      void'($urandom(63208));
      arst_n_i         = 1'b0;
      req_valid_i      = 1'b0;
      req_we_i         = 1'b0;
      req_addr_i       = '0;
      req_be_i         = '0;
      req_wdata_i.word = '0;
      rsp_ready_i      = 1'b1;
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      arst_n_i = 1'b1;

      repeat (3) begin
         @(negedge clk_i);
         a_reset_idle: assert (!rsp_valid_o && req_ready_o) else begin
            mismatch_cnt++;
            $display("MISMATCH %s: expected valid=0 ready=1 actual valid=%b ready=%b",
                     test_name, rsp_valid_o, req_ready_o);
         end
      end

      test_name = "word_rw";  // both banks.
      for (int a = 0; a < 8; a++) send_req(1'b1, `MEM_ADDR_W'(a * 37), '1, 32'h1000_0001 * (a + 1));
      for (int a = 0; a < 8; a++) send_req(1'b0, `MEM_ADDR_W'(a * 37), '1, '0);
      idle(1);
      drain();

      test_name = "byte_enable";
      send_req(1'b1, `MEM_ADDR_W'(20), '1, 32'hAABB_CCDD);
      send_req(1'b1, `MEM_ADDR_W'(20), 4'b0101, 32'h1122_3344);
      send_req(1'b0, `MEM_ADDR_W'(20), '0, '0);  // merged word.
      idle(1);
      drain();

      test_name = "read_first";
      send_req(1'b1, `MEM_ADDR_W'(33), '1, 32'h5A5A_0001);
      send_req(1'b1, `MEM_ADDR_W'(33), '1, 32'h5A5A_0002);
      idle(1);
      drain();

      test_name  = "random";
      rand_ready = 1'b1;
      for (int n = 0; n < 200 && timeout_cnt == 0; n++) begin
         if ($urandom % 3 == 0) idle($urandom % 3 + 1);
         if (n < 100) begin
            rnd_addr = `MEM_ADDR_W'((($urandom % 32) << 1) | (n & 1));  // alternating.
         end else begin
            rnd_addr = `MEM_ADDR_W'($urandom % 64);
         end
         send_req(1'($urandom), rnd_addr, MEM_LANES'($urandom), $urandom);
      end
      idle(1);
      drain();
      rand_ready = 1'b0;

      $display("errors: %0d mismatches, %0d unexpected responses, %0d timeouts",
               mismatch_cnt, unexpected_cnt, timeout_cnt);
      if (mismatch_cnt + unexpected_cnt + timeout_cnt == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
+incdir+rtl
rtl/mem_pkg.sv
rtl/byte_ram_sp.sv
rtl/mem_bank.sv
rtl/interleave_ctrl.sv
rtl/mem_subsys_top.sv
bench/tb_mem_subsys.sv

// ==== Bender.yml ====
package:
  name: mem_subsys

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/mem_pkg.sv
      - rtl/byte_ram_sp.sv
      - rtl/mem_bank.sv
      - rtl/interleave_ctrl.sv
      - rtl/mem_subsys_top.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - bench/tb_mem_subsys.sv
